/* include/udp_echo_macros.svh */
/*
 * Build-time constants for the UDP echo core.
 * DATA_WIDTH and KEEP_WIDTH must stay in step: one keep bit per data byte.
 * The FIFO address width sets the buffer depth to 2**width beats.
 */
`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// Destination port that is answered
`define UDP_ECHO_PORT 16'd1234

// Payload beat width in bits
`define UDP_ECHO_DATA_WIDTH 64

// Byte enables per beat
`define UDP_ECHO_KEEP_WIDTH 8

// Payload FIFO depth as address bits
`define UDP_ECHO_FIFO_ADDR_WIDTH 10

`endif

/* logic/udp_echo_pkg.sv */
/*
 * Shared types for the UDP echo core.
 * Beat widths come from the macros header; header fields are fixed by UDP/IPv4.
 */
`include "udp_echo_macros.svh"

package udp_echo_pkg;

    // Payload beat and its byte enables
    typedef logic [`UDP_ECHO_DATA_WIDTH-1:0] beat_data_t;
    typedef logic [`UDP_ECHO_KEEP_WIDTH-1:0] beat_keep_t;

    // Header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Per-frame payload steering
    typedef enum logic [1:0] {
        FILTER_IDLE,
        FILTER_PASS,
        FILTER_DROP
    } filter_state_t;

endpackage

/* logic/udp_port_filter.sv */
/*
 * Accepts one UDP header per frame and decides echo or discard.
 * Every frame must end with a tlast beat; a header without payload stalls the filter.
 * Header and payload paths are combinational, only the frame state is registered.
 */
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_port_filter (
    input  logic                       clk,
    input  logic                       rst,

    // Header from the upstream stack
    input  logic                       rx_hdr_valid,
    output logic                       rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t     rx_src_ip,
    input  udp_echo_pkg::udp_port_t    rx_src_port,
    input  udp_echo_pkg::udp_port_t    rx_dst_port,
    input  udp_echo_pkg::udp_len_t     rx_length,

    // Payload from the upstream stack
    input  udp_echo_pkg::beat_data_t   rx_tdata,
    input  udp_echo_pkg::beat_keep_t   rx_tkeep,
    input  logic                       rx_tvalid,
    output logic                       rx_tready,
    input  logic                       rx_tlast,
    input  logic                       rx_tuser,

    // Reply header to the downstream stack
    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t     tx_dst_ip,
    output udp_echo_pkg::udp_port_t    tx_src_port,
    output udp_echo_pkg::udp_port_t    tx_dst_port,
    output udp_echo_pkg::udp_len_t     tx_length,

    // Payload into the echo FIFO
    output udp_echo_pkg::beat_data_t   fifo_in_tdata,
    output udp_echo_pkg::beat_keep_t   fifo_in_tkeep,
    output logic                       fifo_in_tvalid,
    input  logic                       fifo_in_tready,
    output logic                       fifo_in_tlast,
    output logic                       fifo_in_tuser
);
    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;

    assign port_match = rx_dst_port == `UDP_ECHO_PORT;

    // Reply goes back to the sender, ports swapped
    assign tx_dst_ip   = rx_src_ip;
    assign tx_src_port = rx_dst_port;
    assign tx_dst_port = rx_src_port;
    assign tx_length   = rx_length;

    // Payload fields pass straight through, only valid is gated
    assign fifo_in_tdata = rx_tdata;
    assign fifo_in_tkeep = rx_tkeep;
    assign fifo_in_tlast = rx_tlast;
    assign fifo_in_tuser = rx_tuser;

    always_comb begin
        rx_hdr_ready   = 1'b0;
        tx_hdr_valid   = 1'b0;
        rx_tready      = 1'b0;
        fifo_in_tvalid = 1'b0;
        state_next     = state;
        case (state)
            FILTER_IDLE: begin
                tx_hdr_valid = rx_hdr_valid && port_match;
                // Non-matching headers are swallowed at once
                if (rx_hdr_valid && (tx_hdr_ready || !port_match)) begin
                    rx_hdr_ready = 1'b1;
                    state_next   = port_match ? FILTER_PASS : FILTER_DROP;
                end
            end
            FILTER_PASS: begin
                fifo_in_tvalid = rx_tvalid;
                rx_tready      = fifo_in_tready;
                if (rx_tvalid && fifo_in_tready && rx_tlast) begin
                    state_next = FILTER_IDLE;
                end
            end
            FILTER_DROP: begin
                rx_tready = 1'b1;
                if (rx_tvalid && rx_tlast) begin
                    state_next = FILTER_IDLE;
                end
            end
            default: begin
                state_next = FILTER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A held reply header keeps its fields until the downstream takes it
    a_hdr_held: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid &&
            $stable({tx_dst_ip, tx_src_port, tx_dst_port, tx_length})
    );

    // A beat stalled by a full FIFO is not withdrawn
    a_fifo_beat_held: assert property (
        @(posedge clk) disable iff (rst)
        fifo_in_tvalid && !fifo_in_tready |=> fifo_in_tvalid && $stable(fifo_in_tdata)
    );

endmodule

/* logic/axis_payload_fifo.sv */
/*
 * Payload FIFO with a registered output stage, no frame awareness.
 * The RAM holds 2**ADDR_WIDTH beats; ready drops when it is full.
 * An empty FIFO forwards a new beat straight into the output stage.
 */
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module axis_payload_fifo #(
    parameter int ADDR_WIDTH = `UDP_ECHO_FIFO_ADDR_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst,

    // Write side
    input  udp_echo_pkg::beat_data_t   in_tdata,
    input  udp_echo_pkg::beat_keep_t   in_tkeep,
    input  logic                       in_tvalid,
    input  logic                       in_tlast,
    input  logic                       in_tuser,
    output logic                       in_tready,

    // Read side
    output udp_echo_pkg::beat_data_t   out_tdata,
    output udp_echo_pkg::beat_keep_t   out_tkeep,
    output logic                       out_tvalid,
    output logic                       out_tlast,
    output logic                       out_tuser,
    input  logic                       out_tready
);
    import udp_echo_pkg::*;

    localparam int DEPTH  = 2 ** ADDR_WIDTH;
    localparam int WORD_W = $bits(beat_data_t) + $bits(beat_keep_t) + 2;

    logic [WORD_W-1:0]   mem [DEPTH];
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] fill_level;
    logic [WORD_W-1:0]   in_word;
    logic [WORD_W-1:0]   out_word;
    logic                out_valid;
    logic                empty;
    logic                full;
    logic                in_fire;
    logic                stage_load;
    logic                ram_read;
    logic                bypass;

    assign in_word = {in_tuser, in_tlast, in_tkeep, in_tdata};

    // Extra pointer bit tells full from empty
    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign fill_level = wr_ptr - rd_ptr;

    assign in_tready  = !full;
    assign in_fire    = in_tvalid && in_tready;
    assign stage_load = !out_valid || out_tready;
    assign ram_read   = stage_load && !empty;
    assign bypass     = stage_load && empty && in_fire;

    always_ff @(posedge clk) begin
        if (in_fire && !bypass) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_fire && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ram_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (stage_load) begin
            out_valid <= ram_read || bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_read) begin
            out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end else if (bypass) begin
            out_word <= in_word;
        end
    end

    assign {out_tuser, out_tlast, out_tkeep, out_tdata} = out_word;
    assign out_tvalid = out_valid;

    // RAM never holds more beats than it has words
    a_no_overfill: assert property (
        @(posedge clk) disable iff (rst) fill_level <= DEPTH
    );

endmodule

/* logic/led_frame_monitor.sv */
/*
 * Shows the low byte of each frame's first beat on the LEDs.
 * Only accepted beats count, so a stalled beat is latched once.
 */
`timescale 1ns/1ps

module led_frame_monitor (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_echo_pkg::beat_data_t   tdata,
    input  logic                       tvalid,
    input  logic                       tready,
    input  logic                       tlast,
    output logic [7:0]                 led
);
    logic in_frame;
    logic beat_fire;

    assign beat_fire = tvalid && tready;

    // Frame tracking on accepted beats
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (beat_fire && tlast) begin
            in_frame <= 1'b0;
        end else if (beat_fire) begin
            in_frame <= 1'b1;
        end
    end

    // First beat of a frame sets the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (beat_fire && !in_frame) begin
            led <= tdata[7:0];
        end
    end

endmodule

/* logic/udp_echo_core.sv */
/*
 * UDP echo between an upstream and a downstream UDP/IP stack.
 * Frames to the echo port come back with ports swapped; all others are dropped.
 * IP source, TTL and checksums are left to the downstream stack.
 */
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_core (
    input  logic                       clk,
    input  logic                       rst,

    // Received UDP header
    input  logic                       rx_hdr_valid,
    output logic                       rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t     rx_src_ip,
    input  udp_echo_pkg::udp_port_t    rx_src_port,
    input  udp_echo_pkg::udp_port_t    rx_dst_port,
    input  udp_echo_pkg::udp_len_t     rx_length,

    // Received payload
    input  udp_echo_pkg::beat_data_t   rx_tdata,
    input  udp_echo_pkg::beat_keep_t   rx_tkeep,
    input  logic                       rx_tvalid,
    output logic                       rx_tready,
    input  logic                       rx_tlast,
    input  logic                       rx_tuser,

    // Reply UDP header
    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t     tx_dst_ip,
    output udp_echo_pkg::udp_port_t    tx_src_port,
    output udp_echo_pkg::udp_port_t    tx_dst_port,
    output udp_echo_pkg::udp_len_t     tx_length,

    // Reply payload
    output udp_echo_pkg::beat_data_t   tx_tdata,
    output udp_echo_pkg::beat_keep_t   tx_tkeep,
    output logic                       tx_tvalid,
    input  logic                       tx_tready,
    output logic                       tx_tlast,
    output logic                       tx_tuser,

    output logic [7:0]                 led
);
    import udp_echo_pkg::*;

    // Filter to FIFO
    beat_data_t fifo_in_tdata;
    beat_keep_t fifo_in_tkeep;
    logic       fifo_in_tvalid;
    logic       fifo_in_tready;
    logic       fifo_in_tlast;
    logic       fifo_in_tuser;

    udp_port_filter filter_i (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_src_ip      (rx_src_ip),
        .rx_src_port    (rx_src_port),
        .rx_dst_port    (rx_dst_port),
        .rx_length      (rx_length),
        .rx_tdata       (rx_tdata),
        .rx_tkeep       (rx_tkeep),
        .rx_tvalid      (rx_tvalid),
        .rx_tready      (rx_tready),
        .rx_tlast       (rx_tlast),
        .rx_tuser       (rx_tuser),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .tx_dst_ip      (tx_dst_ip),
        .tx_src_port    (tx_src_port),
        .tx_dst_port    (tx_dst_port),
        .tx_length      (tx_length),
        .fifo_in_tdata  (fifo_in_tdata),
        .fifo_in_tkeep  (fifo_in_tkeep),
        .fifo_in_tvalid (fifo_in_tvalid),
        .fifo_in_tready (fifo_in_tready),
        .fifo_in_tlast  (fifo_in_tlast),
        .fifo_in_tuser  (fifo_in_tuser)
    );

    axis_payload_fifo #(
        .ADDR_WIDTH (`UDP_ECHO_FIFO_ADDR_WIDTH)
    ) fifo_i (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (fifo_in_tdata),
        .in_tkeep   (fifo_in_tkeep),
        .in_tvalid  (fifo_in_tvalid),
        .in_tlast   (fifo_in_tlast),
        .in_tuser   (fifo_in_tuser),
        .in_tready  (fifo_in_tready),
        .out_tdata  (tx_tdata),
        .out_tkeep  (tx_tkeep),
        .out_tvalid (tx_tvalid),
        .out_tlast  (tx_tlast),
        .out_tuser  (tx_tuser),
        .out_tready (tx_tready)
    );

    // Watches the reply payload as it leaves
    led_frame_monitor monitor_i (
        .clk    (clk),
        .rst    (rst),
        .tdata  (tx_tdata),
        .tvalid (tx_tvalid),
        .tready (tx_tready),
        .tlast  (tx_tlast),
        .led    (led)
    );

endmodule

/* bench/udp_echo_tb.sv */
/*
 * Directed testbench for the UDP echo core.
 * Expected replies come from a queue model fed by the stimulus tasks.
 * DUT outputs are sampled on the falling edge, inputs change 1 ns after the rising edge.
 */
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_tb;
    import udp_echo_pkg::*;

    localparam int WORD_W = `UDP_ECHO_DATA_WIDTH + `UDP_ECHO_KEEP_WIDTH + 2;
    // Headers plus beats of all tests, mixed traffic at its longest
    localparam int TOTAL_ITEMS = (1 + 3) + (1 + 4) + (1 + 20) + 30 * (1 + 8);
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_ITEMS + 300;

    typedef logic [WORD_W-1:0] beat_word_t;
    typedef logic [79:0]       hdr_word_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    ip_addr_t   rx_src_ip;
    udp_port_t  rx_src_port;
    udp_port_t  rx_dst_port;
    udp_len_t   rx_length;
    beat_data_t rx_tdata;
    beat_keep_t rx_tkeep;
    logic       rx_tvalid;
    logic       rx_tready;
    logic       rx_tlast;
    logic       rx_tuser;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    ip_addr_t   tx_dst_ip;
    udp_port_t  tx_src_port;
    udp_port_t  tx_dst_port;
    udp_len_t   tx_length;
    beat_data_t tx_tdata;
    beat_keep_t tx_tkeep;
    logic       tx_tvalid;
    logic       tx_tready;
    logic       tx_tlast;
    logic       tx_tuser;
    logic [7:0] led;

    // Reference model
    hdr_word_t  exp_hdrs[$];
    beat_word_t exp_beats[$];
    beat_word_t frame_beats[$];
    logic [7:0] expected_led = 8'h00;
    logic       frame_match;

    integer      seed = 32'hcb3;
    integer      ready_seed = 32'hcb3;
    logic [31:0] ready_rnd;
    logic        random_ready = 1'b0;
    int          cycles = 0;

    udp_echo_core dut_i (.*);

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    // Random sink back-pressure for mixed traffic
    always @(posedge clk) begin
        if (random_ready) begin
            #1;
            ready_rnd = $random(ready_seed);
            tx_tready = ready_rnd[0];
        end
    end

    // Output checker, one compare per transfer
    always @(negedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (exp_hdrs.size() > 0) else
                stop_with_failure($sformatf("[FAIL] %0t ns: unexpected reply header", $time));
            assert ({tx_dst_ip, tx_src_port, tx_dst_port, tx_length} == exp_hdrs[0]) else
                stop_with_failure($sformatf("[FAIL] %0t ns: reply header %h, expected %h",
                    $time, {tx_dst_ip, tx_src_port, tx_dst_port, tx_length}, exp_hdrs[0]));
            void'(exp_hdrs.pop_front());
        end
        if (!rst && tx_tvalid && tx_tready) begin
            assert (exp_beats.size() > 0) else
                stop_with_failure($sformatf("[FAIL] %0t ns: unexpected reply beat", $time));
            assert ({tx_tuser, tx_tlast, tx_tkeep, tx_tdata} == exp_beats[0]) else
                stop_with_failure($sformatf("[FAIL] %0t ns: reply beat %h, expected %h",
                    $time, {tx_tuser, tx_tlast, tx_tkeep, tx_tdata}, exp_beats[0]));
            void'(exp_beats.pop_front());
        end
    end

    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    function automatic beat_word_t make_beat(beat_data_t d, beat_keep_t k, logic last,
                                             logic user);
        return {user, last, k, d};
    endfunction

    // Offers a header and records the expected reply
    task automatic present_header(ip_addr_t ip, udp_port_t sport, udp_port_t dport,
                                  udp_len_t len);
        rx_src_ip    = ip;
        rx_src_port  = sport;
        rx_dst_port  = dport;
        rx_length    = len;
        rx_hdr_valid = 1'b1;
        frame_match  = dport == `UDP_ECHO_PORT;
        if (frame_match) begin
            // Reply goes back to the sender with ports swapped
            exp_hdrs.push_back({ip, dport, sport, len});
        end
    endtask

    task automatic complete_header();
        do @(negedge clk); while (!rx_hdr_ready);
        drive_slot();
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beats();
        foreach (frame_beats[i]) begin
            {rx_tuser, rx_tlast, rx_tkeep, rx_tdata} = frame_beats[i];
            rx_tvalid = 1'b1;
            if (frame_match) begin
                exp_beats.push_back(frame_beats[i]);
                if (i == 0) begin
                    expected_led = frame_beats[i][7:0];
                end
            end
            do @(negedge clk); while (!rx_tready);
            drive_slot();
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
    endtask

    task automatic send_frame(ip_addr_t ip, udp_port_t sport, udp_port_t dport);
        present_header(ip, sport, dport, 16'(8 + 8 * frame_beats.size()));
        complete_header();
        send_beats();
    endtask

    // Waits for the model to empty, then checks the LEDs
    task automatic drain_and_check_led();
        while (exp_hdrs.size() > 0 || exp_beats.size() > 0) @(negedge clk);
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (led == expected_led) else
            stop_with_failure($sformatf("[FAIL] %0t ns: led %h, expected %h",
                                        $time, led, expected_led));
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (!tx_hdr_valid && !tx_tvalid && !rx_tready && !rx_hdr_ready && led == 8'h00)
        else stop_with_failure($sformatf("[FAIL] %0t ns: outputs not idle after reset", $time));
    endtask

    task automatic echo_matching_frame();
        frame_beats.delete();
        frame_beats.push_back(make_beat(64'h1122334455667788, 8'hff, 1'b0, 1'b0));
        frame_beats.push_back(make_beat(64'h99aabbccddeeff00, 8'hff, 1'b0, 1'b0));
        frame_beats.push_back(make_beat(64'h0000000012345678, 8'h0f, 1'b1, 1'b1));
        drive_slot();
        send_frame(32'hc0a80164, 16'd40000, `UDP_ECHO_PORT);
        drain_and_check_led();
    endtask

    task automatic drop_other_port();
        frame_beats.delete();
        for (int i = 0; i < 4; i++) begin
            frame_beats.push_back(make_beat({32'hdead0000, 32'(i)}, 8'hff, i == 3, 1'b0));
        end
        drive_slot();
        send_frame(32'h0a000001, 16'd5555, 16'd53);
        // Nothing may leave the DUT for a while
        repeat (6) @(negedge clk);
        assert (!tx_tvalid) else
            stop_with_failure($sformatf("[FAIL] %0t ns: dropped frame reached the output",
                                        $time));
        drain_and_check_led();
    endtask

    task automatic backpressure();
        drive_slot();
        tx_hdr_ready = 1'b0;
        tx_tready    = 1'b0;
        frame_beats.delete();
        for (int i = 0; i < 20; i++) begin
            frame_beats.push_back(make_beat({32'h0bad0000 + 32'(i), 32'(i * 7 + 3)},
                                            8'hff, i == 19, i == 19));
        end
        present_header(32'hac100005, 16'd6000, `UDP_ECHO_PORT, 16'd168);
        // Held header must not be accepted upstream
        repeat (8) begin
            @(negedge clk);
            assert (!rx_hdr_ready && tx_hdr_valid) else
                stop_with_failure($sformatf("[FAIL] %0t ns: header not held under back-pressure",
                                            $time));
        end
        drive_slot();
        tx_hdr_ready = 1'b1;
        complete_header();
        send_beats();
        @(negedge clk);
        assert (tx_tvalid && exp_beats.size() == 20) else
            stop_with_failure($sformatf("[FAIL] %0t ns: FIFO did not hold all 20 beats", $time));
        drive_slot();
        tx_tready = 1'b1;
        drain_and_check_led();
    endtask

    task automatic mixed_traffic();
        int          n;
        udp_port_t   dport;
        beat_data_t  d;
        beat_keep_t  keep;
        logic [31:0] rnd;
        random_ready = 1'b1;
        for (int f = 0; f < 30; f++) begin
            rnd = $random(seed);
            n = 1 + (rnd % 8);
            rnd = $random(seed);
            dport = rnd[0] ? `UDP_ECHO_PORT : 16'd7000 + 16'(rnd[15:8]);
            frame_beats.delete();
            for (int b = 0; b < n; b++) begin
                d = {$random(seed), $random(seed)};
                rnd = $random(seed);
                keep = '1;
                if (b == n - 1) begin
                    keep = keep >> rnd[2:0];
                end
                frame_beats.push_back(make_beat(d, keep, b == n - 1, (b == n - 1) && rnd[4]));
            end
            rnd = $random(seed);
            drive_slot();
            send_frame(rnd, 16'd1024 + 16'(f), dport);
        end
        while (exp_hdrs.size() > 0 || exp_beats.size() > 0) @(negedge clk);
        random_ready = 1'b0;
        drive_slot();
        tx_tready = 1'b1;
        drain_and_check_led();
    endtask

    initial begin
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_tdata     = '0;
        rx_tkeep     = '0;
        rx_tvalid    = 1'b0;
        rx_tlast     = 1'b0;
        rx_tuser     = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_tready    = 1'b1;
        frame_match  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        check_reset_state();
        echo_matching_frame();
        drop_other_port();
        backpressure();
        mixed_traffic();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
logic/udp_echo_pkg.sv
logic/udp_port_filter.sv
logic/axis_payload_fifo.sv
logic/led_frame_monitor.sv
logic/udp_echo_core.sv
bench/udp_echo_tb.sv

/* Bender.yml */
package:
  name: udp_echo

sources:
  - include_dirs:
      - include
    files:
      - logic/udp_echo_pkg.sv
      - logic/udp_port_filter.sv
      - logic/axis_payload_fifo.sv
      - logic/led_frame_monitor.sv
      - logic/udp_echo_core.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - bench/udp_echo_tb.sv
